// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_serial_cpu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
src/cpu_pkg.sv
src/cpu_sequencer.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_pc_unit.sv
src/serial_cpu.sv
tb/tb_clock_gen.sv
tb/tb_serial_cpu.sv

// File: src/cpu_alu.sv
module cpu_alu (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::phase_e    phase,
    input  cpu_pkg::instr_t    ir,
    input  cpu_pkg::operands_t operands,
    output cpu_pkg::word_t     result,
    output cpu_pkg::flags_t    flags
);

    cpu_pkg::word_t alu_out;
    logic           alu_cf;
    logic           sets_flags;

    // ----------------------------------------------------------------------
    // combinational datapath
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (ir.op)
            cpu_pkg::AND:
                {alu_cf, alu_out} = {1'b0, operands.a & operands.b};
            cpu_pkg::OR:
                {alu_cf, alu_out} = {1'b0, operands.a | operands.b};
            cpu_pkg::XOR:
                {alu_cf, alu_out} = {1'b0, operands.a ^ operands.b};
            // shifts keep the old carry
            cpu_pkg::SLL:
                {alu_cf, alu_out} = {flags.cf, operands.a << operands.b[3:0]};
            cpu_pkg::SRL:
                {alu_cf, alu_out} = {flags.cf, operands.a >> operands.b[3:0]};
            cpu_pkg::SET:
                {alu_cf, alu_out} = {flags.cf, operands.b};
            // bit 16 is the borrow
            cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP:
                {alu_cf, alu_out} = {1'b0, operands.a} - {1'b0, operands.b};
            // also address and branch target
            default:
                {alu_cf, alu_out} = {1'b0, operands.a} + {1'b0, operands.b};
        endcase
    end

    always_comb
    begin
        case (ir.op)
            cpu_pkg::LDIH, cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI,
            cpu_pkg::CMP, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SLL,
            cpu_pkg::SRL:
                sets_flags = 1'b1;
            default:
                sets_flags = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // result and flags, loaded at the end of EX
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result <= '0;
            flags  <= '0;
        end
        else if (phase == cpu_pkg::EX)
        begin
            result <= alu_out;
            if (sets_flags)
            begin
                flags.zf <= (alu_out == '0);
                flags.nf <= alu_out[15];
                flags.cf <= alu_cf;
            end
        end
    end

endmodule

// File: src/cpu_pc_unit.sv
module cpu_pc_unit #(
    parameter int PC_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  cpu_pkg::phase_e     phase,
    input  cpu_pkg::instr_t     ir,
    input  cpu_pkg::flags_t     flags,
    input  cpu_pkg::word_t      result,
    output logic [PC_WIDTH-1:0] pc,
    output logic                at_end
);

    logic taken;

    // branch decision on the flags of earlier instructions
    always_comb
    begin
        case (ir.op)
            cpu_pkg::JUMP: taken = 1'b1;
            cpu_pkg::BZ:   taken = flags.zf;
            cpu_pkg::BNZ:  taken = !flags.zf;
            cpu_pkg::BN:   taken = flags.nf;
            cpu_pkg::BNN:  taken = !flags.nf;
            cpu_pkg::BC:   taken = flags.cf;
            cpu_pkg::BNC:  taken = !flags.cf;
            default:       taken = 1'b0;
        endcase
    end

    // last instruction slot reached
    assign at_end = &pc;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= '0;
        else if (phase == cpu_pkg::IDLE && start)
            pc <= '0;
        else if (phase == cpu_pkg::WB)
        begin
            if (taken)
                pc <= result[PC_WIDTH-1:0];
            else if (!at_end)
                pc <= pc + 1'b1;
        end
    end

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

    // ----------------------------------------------------------------------
    // data widths
    // ----------------------------------------------------------------------

    // register and ALU word
    typedef logic [15:0] word_t;
    // one byte on the memory buses
    typedef logic [7:0]  byte_t;
    // general register number
    typedef logic [2:0]  reg_idx_t;

    // ----------------------------------------------------------------------
    // instruction format
    // ----------------------------------------------------------------------

    typedef enum logic [4:0] {
        NOP   = 5'd0,
        HALT  = 5'd1,
        LOAD  = 5'd2,
        STORE = 5'd3,
        LDIH  = 5'd4,
        ADD   = 5'd5,
        ADDI  = 5'd6,
        SUB   = 5'd7,
        SUBI  = 5'd8,
        CMP   = 5'd9,
        AND   = 5'd10,
        OR    = 5'd11,
        XOR   = 5'd12,
        SLL   = 5'd13,
        SRL   = 5'd14,
        SET   = 5'd15,
        JUMP  = 5'd16,
        BZ    = 5'd17,
        BNZ   = 5'd18,
        BN    = 5'd19,
        BNN   = 5'd20,
        BC    = 5'd21,
        BNC   = 5'd22
    } opcode_e;

    // f2 and f3 are either register numbers or immediate nibbles
    typedef struct packed {
        opcode_e    op;
        reg_idx_t   r1;
        logic [3:0] f2;
        logic [3:0] f3;
    } instr_t;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------

    // eight phases per instruction after IDLE
    typedef enum logic [3:0] {
        IDLE = 4'b0000,
        IF   = 4'b0001,
        IF2  = 4'b0011,
        ID   = 4'b0010,
        EX   = 4'b0110,
        EX2  = 4'b0100,
        MEM  = 4'b0101,
        MEM2 = 4'b0111,
        WB   = 4'b1111
    } phase_e;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t sdata;
    } operands_t;

    typedef struct packed {
        logic zf;
        logic nf;
        logic cf;
    } flags_t;

    // why the last run stopped
    typedef enum logic [1:0] {
        NONE           = 2'd0,
        HALTED         = 2'd1,
        END_OF_PROGRAM = 2'd2
    } stop_e;

endpackage

// File: src/cpu_regfile.sv
module cpu_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::phase_e    phase,
    input  cpu_pkg::instr_t    ir,
    input  cpu_pkg::byte_t     d_rdata,
    input  cpu_pkg::word_t     result,
    output cpu_pkg::operands_t operands
);

    cpu_pkg::word_t    gr [8];
    cpu_pkg::reg_idx_t r2;
    cpu_pkg::reg_idx_t r3;
    logic              is_load;
    logic              writes_r1;

    assign r2      = ir.f2[2:0];
    assign r3      = ir.f3[2:0];
    assign is_load = (ir.op == cpu_pkg::LOAD);

    // instructions that leave their result in r1
    always_comb
    begin
        case (ir.op)
            cpu_pkg::LDIH, cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI,
            cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRL,
            cpu_pkg::SET:
                writes_r1 = 1'b1;
            default:
                writes_r1 = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // operand select in ID
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            operands <= '0;
        else if (phase == cpu_pkg::ID)
        begin
            case (ir.op)
                cpu_pkg::JUMP:
                    operands.a <= '0;
                cpu_pkg::LDIH, cpu_pkg::ADDI, cpu_pkg::SUBI, cpu_pkg::SET,
                cpu_pkg::BZ, cpu_pkg::BNZ, cpu_pkg::BN, cpu_pkg::BNN,
                cpu_pkg::BC, cpu_pkg::BNC:
                    operands.a <= gr[ir.r1];
                cpu_pkg::LOAD, cpu_pkg::STORE, cpu_pkg::ADD, cpu_pkg::SUB,
                cpu_pkg::CMP, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR,
                cpu_pkg::SLL, cpu_pkg::SRL:
                    operands.a <= gr[r2];
                default:
                    operands.a <= operands.a;
            endcase

            case (ir.op)
                // offset or shift amount
                cpu_pkg::LOAD, cpu_pkg::STORE, cpu_pkg::SLL, cpu_pkg::SRL:
                    operands.b <= {12'd0, ir.f3};
                cpu_pkg::ADDI, cpu_pkg::SUBI, cpu_pkg::SET, cpu_pkg::JUMP,
                cpu_pkg::BZ, cpu_pkg::BNZ, cpu_pkg::BN, cpu_pkg::BNN,
                cpu_pkg::BC, cpu_pkg::BNC:
                    operands.b <= {8'd0, ir.f2, ir.f3};
                cpu_pkg::LDIH:
                    operands.b <= {ir.f2, ir.f3, 8'd0};
                cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::CMP, cpu_pkg::AND,
                cpu_pkg::OR, cpu_pkg::XOR:
                    operands.b <= gr[r3];
                default:
                    operands.b <= operands.b;
            endcase

            if (ir.op == cpu_pkg::STORE)
                operands.sdata <= gr[ir.r1];
        end
    end

    // ----------------------------------------------------------------------
    // register writes, load bytes and writeback
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                gr[i] <= '0;
        end
        else if (phase == cpu_pkg::MEM && is_load)
            gr[ir.r1][7:0] <= d_rdata;
        else if (phase == cpu_pkg::MEM2 && is_load)
            gr[ir.r1][15:8] <= d_rdata;
        else if (phase == cpu_pkg::WB && writes_r1)
            gr[ir.r1] <= result;
    end

endmodule

// File: src/cpu_sequencer.sv
module cpu_sequencer #(
    parameter int PC_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  cpu_pkg::byte_t      i_data,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                at_end,
    input  cpu_pkg::word_t      result,
    input  cpu_pkg::operands_t  operands,
    output cpu_pkg::phase_e     phase,
    output cpu_pkg::instr_t     ir,
    output logic [PC_WIDTH:0]   i_addr,
    output logic [PC_WIDTH:0]   d_addr,
    output logic                d_we,
    output cpu_pkg::byte_t      d_wdata,
    output cpu_pkg::stop_e      stop
);

    cpu_pkg::phase_e next_phase;
    cpu_pkg::word_t  ir_word;
    logic            byte_sel;
    logic            is_store;

    // ----------------------------------------------------------------------
    // phase FSM
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (phase)
            cpu_pkg::IDLE: next_phase = start ? cpu_pkg::IF : cpu_pkg::IDLE;
            cpu_pkg::IF:   next_phase = cpu_pkg::IF2;
            cpu_pkg::IF2:  next_phase = cpu_pkg::ID;
            cpu_pkg::ID:   next_phase = cpu_pkg::EX;
            cpu_pkg::EX:   next_phase = cpu_pkg::EX2;
            cpu_pkg::EX2:  next_phase = cpu_pkg::MEM;
            cpu_pkg::MEM:  next_phase = cpu_pkg::MEM2;
            cpu_pkg::MEM2: next_phase = cpu_pkg::WB;
            cpu_pkg::WB:
                if (ir.op == cpu_pkg::HALT || at_end)
                    next_phase = cpu_pkg::IDLE;
                else
                    next_phase = cpu_pkg::IF;
            default:       next_phase = cpu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            phase <= cpu_pkg::IDLE;
        else
            phase <= next_phase;
    end

    // stop cause, cleared again by the next start
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            stop <= cpu_pkg::NONE;
        else if (phase == cpu_pkg::IDLE && start)
            stop <= cpu_pkg::NONE;
        else if (phase == cpu_pkg::WB)
        begin
            if (ir.op == cpu_pkg::HALT)
                stop <= cpu_pkg::HALTED;
            else if (at_end)
                stop <= cpu_pkg::END_OF_PROGRAM;
        end
    end

    // ----------------------------------------------------------------------
    // fetch, low byte first
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir_word <= '0;
        else if (phase == cpu_pkg::IF)
            ir_word[7:0] <= i_data;
        else if (phase == cpu_pkg::IF2)
            ir_word[15:8] <= i_data;
    end

    assign ir = cpu_pkg::instr_t'(ir_word);

    // ----------------------------------------------------------------------
    // byte buses
    // ----------------------------------------------------------------------

    // second byte of each transfer
    assign byte_sel = (phase == cpu_pkg::IF2) || (phase == cpu_pkg::MEM2);

    assign i_addr = {pc, byte_sel};
    assign d_addr = {result[PC_WIDTH-1:0], byte_sel};

    assign is_store = (ir.op == cpu_pkg::STORE);
    assign d_we     = is_store && (phase == cpu_pkg::MEM || phase == cpu_pkg::MEM2);
    assign d_wdata  = byte_sel ? operands.sdata[15:8] : operands.sdata[7:0];

endmodule

// File: src/serial_cpu.sv
module serial_cpu #(
    parameter int PC_WIDTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  cpu_pkg::byte_t    i_data,
    input  cpu_pkg::byte_t    d_rdata,
    output logic [PC_WIDTH:0] i_addr,
    output logic [PC_WIDTH:0] d_addr,
    output logic              d_we,
    output cpu_pkg::byte_t    d_wdata,
    output cpu_pkg::stop_e    stop
);

    cpu_pkg::phase_e     phase;
    cpu_pkg::instr_t     ir;
    cpu_pkg::operands_t  operands;
    cpu_pkg::word_t      result;
    cpu_pkg::flags_t     flags;
    logic [PC_WIDTH-1:0] pc;
    logic                at_end;

    // ----------------------------------------------------------------------
    // control and bus muxing
    // ----------------------------------------------------------------------

    cpu_sequencer #(
        .PC_WIDTH (PC_WIDTH)
    ) u_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .i_data   (i_data),
        .pc       (pc),
        .at_end   (at_end),
        .result   (result),
        .operands (operands),
        .phase    (phase),
        .ir       (ir),
        .i_addr   (i_addr),
        .d_addr   (d_addr),
        .d_we     (d_we),
        .d_wdata  (d_wdata),
        .stop     (stop)
    );

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------

    cpu_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase    (phase),
        .ir       (ir),
        .d_rdata  (d_rdata),
        .result   (result),
        .operands (operands)
    );

    cpu_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase    (phase),
        .ir       (ir),
        .operands (operands),
        .result   (result),
        .flags    (flags)
    );

    // next pc beside the ALU
    cpu_pc_unit #(
        .PC_WIDTH (PC_WIDTH)
    ) u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .phase    (phase),
        .ir       (ir),
        .flags    (flags),
        .result   (result),
        .pc       (pc),
        .at_end   (at_end)
    );

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release a little after the edge, like the other stimulus
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: tb/tb_serial_cpu.sv
module tb_serial_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PC_WIDTH    = 8;
    localparam int RUN_TIMEOUT = 5000;
    localparam int MODEL_STEPS = 4096;

    logic                clk;
    logic                rst_n;
    logic                start;
    cpu_pkg::byte_t      i_data;
    cpu_pkg::byte_t      d_rdata;
    logic [PC_WIDTH:0]   i_addr;
    logic [PC_WIDTH:0]   d_addr;
    logic                d_we;
    cpu_pkg::byte_t      d_wdata;
    cpu_pkg::stop_e      stop;

    cpu_pkg::byte_t      imem [512];
    cpu_pkg::byte_t      dmem [512];
    cpu_pkg::byte_t      exp_mem [512];
    cpu_pkg::word_t      prog [256];

    // architectural state of the model, kept across runs like the DUT
    cpu_pkg::word_t      m_regs [8];
    logic                m_zf;
    logic                m_nf;
    logic                m_cf;

    logic [31:0]         rnd_state;
    int                  run_count;
    int                  checked_runs;
    event                run_done;

    tb_clock_gen #(
        .HALF_PERIOD  (10),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    serial_cpu #(
        .PC_WIDTH (PC_WIDTH)
    ) i_serial_cpu (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .i_data  (i_data),
        .d_rdata (d_rdata),
        .i_addr  (i_addr),
        .d_addr  (d_addr),
        .d_we    (d_we),
        .d_wdata (d_wdata),
        .stop    (stop)
    );

    // ----------------------------------------------------------------------
    // memories
    // ----------------------------------------------------------------------

    assign i_data  = imem[i_addr];
    assign d_rdata = dmem[d_addr];

    always @(posedge clk)
    begin
        if (d_we)
            dmem[d_addr] = d_wdata;
    end

    function automatic cpu_pkg::byte_t fill_byte(logic [8:0] addr);
        return (addr[7:0] * 8'd37) ^ {addr[8], addr[8:2]};
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
        return rnd_state;
    endfunction

    // ----------------------------------------------------------------------
    // failure reporting and checks
    // ----------------------------------------------------------------------

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // ----------------------------------------------------------------------
    // program building
    // ----------------------------------------------------------------------

    function automatic cpu_pkg::word_t encode_rrr(cpu_pkg::opcode_e op, int r1, int f2, int f3);
        return {op, r1[2:0], f2[3:0], f3[3:0]};
    endfunction

    function automatic cpu_pkg::word_t encode_imm(cpu_pkg::opcode_e op, int r1, int imm);
        return {op, r1[2:0], imm[7:0]};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 256; i++)
            prog[i] = encode_rrr(cpu_pkg::NOP, 0, 0, 0);
    endtask

    // two bytes per instruction, low byte first
    task automatic load_program();
        logic [8:0] addr;
        for (int i = 0; i < 256; i++)
        begin
            addr = {i[7:0], 1'b0};
            imem[addr] = prog[i][7:0];
            imem[addr | 9'd1] = prog[i][15:8];
        end
    endtask

    function automatic cpu_pkg::opcode_e pick_op(logic [15:0] k);
        case (k % 16'd13)
            16'd0:   return cpu_pkg::LDIH;
            16'd1:   return cpu_pkg::ADD;
            16'd2:   return cpu_pkg::ADDI;
            16'd3:   return cpu_pkg::SUB;
            16'd4:   return cpu_pkg::SUBI;
            16'd5:   return cpu_pkg::CMP;
            16'd6:   return cpu_pkg::AND;
            16'd7:   return cpu_pkg::OR;
            16'd8:   return cpu_pkg::XOR;
            16'd9:   return cpu_pkg::SLL;
            16'd10:  return cpu_pkg::SRL;
            16'd11:  return cpu_pkg::SET;
            default: return cpu_pkg::STORE;
        endcase
    endfunction

    task automatic build_random_program();
        logic [31:0] r;
        logic [31:0] s;
        clear_program();
        for (int n = 0; n < 20; n++)
        begin
            r = next_rand();
            s = next_rand();
            prog[n] = {pick_op(r[31:16]), s[18:16], s[22:19], s[26:23]};
        end
        // dump all registers relative to r0
        for (int i = 0; i < 8; i++)
            prog[20 + i] = encode_rrr(cpu_pkg::STORE, i, 0, i);
        prog[28] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
    endtask

    // ----------------------------------------------------------------------
    // instruction-level reference model
    // ----------------------------------------------------------------------

    function automatic cpu_pkg::stop_e run_model();
        cpu_pkg::instr_t ins;
        cpu_pkg::word_t  a;
        cpu_pkg::word_t  b;
        cpu_pkg::word_t  res;
        logic            carry;
        logic            taken;
        logic [7:0]      pc;
        int              steps;
        cpu_pkg::stop_e  why;

        pc = 8'd0;
        why = cpu_pkg::NONE;
        steps = 0;
        while (why == cpu_pkg::NONE && steps < MODEL_STEPS)
        begin
            ins = cpu_pkg::instr_t'(prog[pc]);

            case (ins.op)
                cpu_pkg::JUMP:
                    a = 16'd0;
                cpu_pkg::LOAD, cpu_pkg::STORE, cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::CMP,
                cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRL:
                    a = m_regs[ins.f2[2:0]];
                default:
                    a = m_regs[ins.r1];
            endcase

            case (ins.op)
                cpu_pkg::LOAD, cpu_pkg::STORE, cpu_pkg::SLL, cpu_pkg::SRL:
                    b = {12'd0, ins.f3};
                cpu_pkg::LDIH:
                    b = {ins.f2, ins.f3, 8'd0};
                cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::CMP, cpu_pkg::AND,
                cpu_pkg::OR, cpu_pkg::XOR:
                    b = m_regs[ins.f3[2:0]];
                default:
                    b = {8'd0, ins.f2, ins.f3};
            endcase

            carry = m_cf;
            case (ins.op)
                cpu_pkg::AND:
                begin
                    res = a & b;
                    carry = 1'b0;
                end
                cpu_pkg::OR:
                begin
                    res = a | b;
                    carry = 1'b0;
                end
                cpu_pkg::XOR:
                begin
                    res = a ^ b;
                    carry = 1'b0;
                end
                cpu_pkg::SLL: res = a << b[3:0];
                cpu_pkg::SRL: res = a >> b[3:0];
                cpu_pkg::SET: res = b;
                cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP:
                begin
                    res = a - b;
                    carry = (a < b);
                end
                default:
                begin
                    res = a + b;
                    carry = (res < a);
                end
            endcase

            case (ins.op)
                cpu_pkg::LDIH, cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI,
                cpu_pkg::CMP, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SLL,
                cpu_pkg::SRL:
                begin
                    m_zf = (res == 16'd0);
                    m_nf = res[15];
                    m_cf = carry;
                end
                default: ;
            endcase

            case (ins.op)
                cpu_pkg::JUMP: taken = 1'b1;
                cpu_pkg::BZ:   taken = m_zf;
                cpu_pkg::BNZ:  taken = !m_zf;
                cpu_pkg::BN:   taken = m_nf;
                cpu_pkg::BNN:  taken = !m_nf;
                cpu_pkg::BC:   taken = m_cf;
                cpu_pkg::BNC:  taken = !m_cf;
                default:       taken = 1'b0;
            endcase

            case (ins.op)
                cpu_pkg::LDIH, cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI,
                cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRL,
                cpu_pkg::SET:
                    m_regs[ins.r1] = res;
                cpu_pkg::LOAD:
                    m_regs[ins.r1] = {exp_mem[{res[7:0], 1'b1}], exp_mem[{res[7:0], 1'b0}]};
                cpu_pkg::STORE:
                begin
                    exp_mem[{res[7:0], 1'b0}] = m_regs[ins.r1][7:0];
                    exp_mem[{res[7:0], 1'b1}] = m_regs[ins.r1][15:8];
                end
                default: ;
            endcase

            // the last slot still executes before the run ends
            if (ins.op == cpu_pkg::HALT)
                why = cpu_pkg::HALTED;
            else if (pc == 8'hff)
                why = cpu_pkg::END_OF_PROGRAM;

            if (taken)
                pc = res[7:0];
            else if (pc != 8'hff)
                pc = pc + 8'd1;
            steps++;
        end
        return why;
    endfunction

    // ----------------------------------------------------------------------
    // comparison of each finished run
    // ----------------------------------------------------------------------

    task automatic compare_run();
        cpu_pkg::stop_e exp_stop;
        exp_stop = run_model();
        if (exp_stop == cpu_pkg::NONE)
            fail_now("reference model did not reach HALT or the end of the program");
        else
        begin
            check("stop", 32'(stop), 32'(exp_stop));
            for (int i = 0; i < 512; i++)
                check($sformatf("dmem[0x%03h]", i), 32'(dmem[i]), 32'(exp_mem[i]));
            checked_runs++;
        end
    endtask

    always
    begin
        @(run_done);
        compare_run();
    end

    // start one program and wait for its stop report
    task automatic run_and_compare();
        int cycles;
        load_program();
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check("stop", 32'(stop), 32'(cpu_pkg::NONE));
        cycles = 0;
        while (stop == cpu_pkg::NONE)
        begin
            if (cycles >= RUN_TIMEOUT)
                fail_now("timeout: the CPU did not report a stop");
            else
            begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
        run_count++;
        -> run_done;
        cycles = 0;
        while (checked_runs != run_count)
        begin
            if (cycles >= 4)
                fail_now("timeout: the comparison of a run did not finish");
            else
            begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // directed programs
    // ----------------------------------------------------------------------

    task automatic build_alu_program();
        clear_program();
        prog[0]  = encode_imm(cpu_pkg::SET, 1, 8'h34);
        prog[1]  = encode_imm(cpu_pkg::LDIH, 1, 8'h12);
        prog[2]  = encode_imm(cpu_pkg::SET, 2, 8'h0f);
        prog[3]  = encode_imm(cpu_pkg::ADDI, 2, 8'h21);
        prog[4]  = encode_imm(cpu_pkg::SUBI, 2, 8'h05);
        prog[5]  = encode_rrr(cpu_pkg::ADD, 3, 1, 2);
        prog[6]  = encode_rrr(cpu_pkg::SUB, 4, 1, 2);
        prog[7]  = encode_rrr(cpu_pkg::AND, 5, 1, 2);
        prog[8]  = encode_rrr(cpu_pkg::OR, 6, 1, 2);
        prog[9]  = encode_rrr(cpu_pkg::XOR, 7, 3, 4);
        prog[10] = encode_rrr(cpu_pkg::SLL, 3, 3, 3);
        prog[11] = encode_rrr(cpu_pkg::SRL, 4, 4, 5);
        prog[12] = encode_imm(cpu_pkg::SET, 0, 8'h40);
        for (int i = 1; i < 8; i++)
            prog[12 + i] = encode_rrr(cpu_pkg::STORE, i, 0, i - 1);
        prog[20] = encode_rrr(cpu_pkg::STORE, 0, 0, 7);
        prog[21] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
    endtask

    task automatic build_round_trip_program();
        clear_program();
        prog[0] = encode_imm(cpu_pkg::SET, 1, 8'ha5);
        prog[1] = encode_imm(cpu_pkg::LDIH, 1, 8'h5c);
        prog[2] = encode_imm(cpu_pkg::SET, 0, 8'h80);
        prog[3] = encode_rrr(cpu_pkg::STORE, 1, 0, 1);
        prog[4] = encode_rrr(cpu_pkg::LOAD, 2, 0, 1);
        prog[5] = encode_rrr(cpu_pkg::STORE, 2, 0, 2);
        prog[6] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
    endtask

    // r7 stays zero so branch targets are plain immediates
    task automatic build_branch_program();
        clear_program();
        prog[0]  = encode_imm(cpu_pkg::SET, 7, 8'h00);
        prog[1]  = encode_imm(cpu_pkg::SET, 0, 8'h90);
        prog[2]  = encode_imm(cpu_pkg::SET, 1, 8'h04);
        prog[3]  = encode_rrr(cpu_pkg::STORE, 1, 0, 0);
        prog[4]  = encode_imm(cpu_pkg::ADDI, 0, 8'h01);
        prog[5]  = encode_imm(cpu_pkg::SUBI, 1, 8'h01);
        prog[6]  = encode_imm(cpu_pkg::BNZ, 7, 3);
        prog[7]  = encode_rrr(cpu_pkg::CMP, 0, 1, 7);
        prog[8]  = encode_imm(cpu_pkg::BZ, 7, 10);
        prog[9]  = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
        prog[10] = encode_imm(cpu_pkg::SUBI, 1, 8'h01);
        prog[11] = encode_imm(cpu_pkg::BN, 7, 13);
        prog[12] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
        prog[13] = encode_imm(cpu_pkg::BC, 7, 15);
        prog[14] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
        prog[15] = encode_rrr(cpu_pkg::STORE, 1, 0, 0);
        prog[16] = encode_imm(cpu_pkg::ADDI, 1, 8'h02);
        prog[17] = encode_imm(cpu_pkg::BNN, 7, 19);
        prog[18] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
        prog[19] = encode_rrr(cpu_pkg::ADD, 3, 7, 7);
        prog[20] = encode_imm(cpu_pkg::BNC, 7, 22);
        prog[21] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
        // not taken, zf is set
        prog[22] = encode_imm(cpu_pkg::BNZ, 7, 25);
        prog[23] = encode_rrr(cpu_pkg::STORE, 1, 0, 1);
        prog[24] = encode_imm(cpu_pkg::JUMP, 0, 27);
        prog[25] = encode_rrr(cpu_pkg::STORE, 7, 0, 2);
        prog[26] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
        prog[27] = encode_rrr(cpu_pkg::STORE, 0, 0, 3);
        prog[28] = encode_rrr(cpu_pkg::HALT, 0, 0, 0);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial
    begin
        int cycles;

        start = 1'b0;
        rnd_state = 32'd74;
        run_count = 0;
        checked_runs = 0;
        m_zf = 1'b0;
        m_nf = 1'b0;
        m_cf = 1'b0;
        for (int i = 0; i < 8; i++)
            m_regs[i] = 16'd0;
        for (int i = 0; i < 512; i++)
        begin
            imem[i] = 8'h00;
            dmem[i] = fill_byte(9'(i));
            exp_mem[i] = dmem[i];
        end

        cycles = 0;
        while (rst_n !== 1'b1)
        begin
            if (cycles >= 20)
                fail_now("timeout: reset was never released");
            else
            begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end

        check("stop", 32'(stop), 32'(cpu_pkg::NONE));
        check("d_we", 32'(d_we), 32'd0);

        build_alu_program();
        run_and_compare();
        check("stop", 32'(stop), 32'(cpu_pkg::HALTED));

        build_round_trip_program();
        run_and_compare();
        check("dmem[0x104]", 32'(dmem[9'h104]), 32'ha5);
        check("dmem[0x105]", 32'(dmem[9'h105]), 32'h5c);

        build_branch_program();
        run_and_compare();

        // no HALT, the pc runs into the last slot
        clear_program();
        run_and_compare();
        check("stop", 32'(stop), 32'(cpu_pkg::END_OF_PROGRAM));
        run_and_compare();
        check("stop", 32'(stop), 32'(cpu_pkg::END_OF_PROGRAM));

        for (int n = 0; n < 20; n++)
        begin
            build_random_program();
            run_and_compare();
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
